/* common/radio_fe_pkg.sv */
package radio_fe_pkg;

   ////////////////////////////////////////
   // Sample and settings types
   ////////////////////////////////////////
   typedef logic signed [15:0] sample_t;   // One I or Q component
   typedef logic [31:0]        iq_t;       // I in [31:16], Q in [15:0]
   typedef logic [7:0]         set_addr_t;
   typedef logic [31:0]        set_data_t;

   localparam sample_t SAMPLE_MAX = sample_t'(32767);
   localparam sample_t SAMPLE_MIN = sample_t'(-32768);

   ////////////////////////////////////////
   // Register bases and bit positions
   ////////////////////////////////////////
   localparam int unsigned SET_TX_FE_BASE = 224;
   localparam int unsigned SET_RX_FE_BASE = 232;
   localparam int unsigned SET_CTRL_ADDR  = 240;

   localparam int TX_SWAP_BIT   = 0;   // TX mux register
   localparam int RX_SWAP_BIT   = 0;   // RX IQ mapping register
   localparam int RX_NEG_Q_BIT  = 1;
   localparam int TX_ENABLE_BIT = 0;   // Control register

   // Clip a 17-bit two's complement result into the sample range
   function automatic sample_t sat_17(logic [16:0] wide);
      sample_t res;
      case (wide[16:15])
         2'b01:   res = SAMPLE_MAX;   // Positive overflow
         2'b10:   res = SAMPLE_MIN;   // Negative overflow
         default: res = sample_t'(wide[15:0]);
      endcase
      return res;
   endfunction

   function automatic sample_t sat_add(sample_t a, sample_t b);
      return sat_17({a[15], a} + {b[15], b});
   endfunction

   function automatic sample_t sat_sub(sample_t a, sample_t b);
      return sat_17({a[15], a} - {b[15], b});
   endfunction

endpackage

/* common/fe_cfg_if.sv */
interface fe_cfg_if;
   import radio_fe_pkg::*;

   // TX frontend settings
   sample_t tx_off_i;
   sample_t tx_off_q;
   logic    tx_swap;
   logic    tx_enable;   // Lets samples leave the TX FIFO

   // RX frontend settings
   sample_t rx_off_i;
   sample_t rx_off_q;
   logic    rx_swap;
   logic    rx_neg_q;

   // Register block drives everything
   modport regs (
      output tx_off_i, tx_off_q, tx_swap, tx_enable,
      output rx_off_i, rx_off_q, rx_swap, rx_neg_q
   );

   modport tx (
      input tx_off_i, tx_off_q, tx_swap, tx_enable
   );

   modport rx (
      input rx_off_i, rx_off_q, rx_swap, rx_neg_q
   );

endinterface

/* rtl/fe_settings_regs.sv */
module fe_settings_regs (
   input  logic                    radio_clk,
   input  logic                    rst_n_i,
   input  logic                    set_stb_i,
   input  radio_fe_pkg::set_addr_t set_addr_i,
   input  radio_fe_pkg::set_data_t set_data_i,
   fe_cfg_if.regs                  cfg
);
   import radio_fe_pkg::*;

   ////////////////////////////////////////
   // Address map
   ////////////////////////////////////////
   localparam set_addr_t ADDR_TX_OFF_I = set_addr_t'(SET_TX_FE_BASE + 0);
   localparam set_addr_t ADDR_TX_OFF_Q = set_addr_t'(SET_TX_FE_BASE + 1);
   localparam set_addr_t ADDR_TX_MUX   = set_addr_t'(SET_TX_FE_BASE + 4);
   localparam set_addr_t ADDR_RX_OFF_I = set_addr_t'(SET_RX_FE_BASE + 2);
   localparam set_addr_t ADDR_RX_OFF_Q = set_addr_t'(SET_RX_FE_BASE + 3);
   localparam set_addr_t ADDR_RX_MAP   = set_addr_t'(SET_RX_FE_BASE + 4);
   localparam set_addr_t ADDR_CTRL     = set_addr_t'(SET_CTRL_ADDR);

   // Offsets come from the low half of the data word
   sample_t set_off;

   assign set_off = sample_t'(set_data_i[15:0]);

   always_ff @(posedge radio_clk) begin
      if (!rst_n_i) begin
         cfg.tx_off_i  <= '0;
         cfg.tx_off_q  <= '0;
         cfg.tx_swap   <= 1'b0;
         cfg.tx_enable <= 1'b0;   // TX held off until enabled
         cfg.rx_off_i  <= '0;
         cfg.rx_off_q  <= '0;
         cfg.rx_swap   <= 1'b0;
         cfg.rx_neg_q  <= 1'b0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_TX_OFF_I: cfg.tx_off_i <= set_off;
            ADDR_TX_OFF_Q: cfg.tx_off_q <= set_off;
            ADDR_TX_MUX:   cfg.tx_swap  <= set_data_i[TX_SWAP_BIT];
            ADDR_RX_OFF_I: cfg.rx_off_i <= set_off;
            ADDR_RX_OFF_Q: cfg.rx_off_q <= set_off;
            ADDR_RX_MAP: begin
               cfg.rx_swap  <= set_data_i[RX_SWAP_BIT];
               cfg.rx_neg_q <= set_data_i[RX_NEG_Q_BIT];
            end
            ADDR_CTRL:     cfg.tx_enable <= set_data_i[TX_ENABLE_BIT];
            default: ;   // Unmapped, dropped
         endcase
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_set_addr_known : assert property (
      @(posedge radio_clk) disable iff (!rst_n_i)
      set_stb_i |-> !$isunknown(set_addr_i)
   ) else $error("settings address unknown during strobe");

endmodule

/* tx_frontend/tx_sample_fifo.sv */
module tx_sample_fifo #(
   parameter int TX_FIFO_DEPTH = 4
) (
   input  logic              radio_clk,
   input  logic              rst_n_i,
   input  logic              tx_valid_i,
   input  radio_fe_pkg::iq_t tx_iq_i,
   fe_cfg_if.tx              cfg,
   output logic              pop_o,
   output radio_fe_pkg::iq_t pop_iq_o,
   output logic              tx_credit_o
);
   import radio_fe_pkg::*;

   localparam int PTR_W = $clog2(TX_FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   iq_t              mem [TX_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic             full;

   assign full     = (fill == CNT_W'(TX_FIFO_DEPTH));
   assign pop_o    = cfg.tx_enable && (fill != '0);   // Drain while enabled
   assign pop_iq_o = mem[rd_ptr];

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (tx_valid_i)
         mem[wr_ptr] <= tx_iq_i;
   end

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge radio_clk) begin
      if (!rst_n_i) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         fill        <= '0;
         tx_credit_o <= 1'b0;
      end else begin
         if (tx_valid_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_o)
            rd_ptr <= rd_ptr + 1'b1;
         case ({tx_valid_i, pop_o})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: ;   // Both or neither
         endcase
         tx_credit_o <= pop_o;   // One credit back per sample out
      end
   end

   ////////////////////////////////////////
   // Credit protocol checks
   ////////////////////////////////////////
   a_no_write_full : assert property (
      @(posedge radio_clk) disable iff (!rst_n_i)
      tx_valid_i |-> !full
   ) else $error("TX sample written with no credit left");

   a_fill_bound : assert property (
      @(posedge radio_clk) disable iff (!rst_n_i)
      fill <= CNT_W'(TX_FIFO_DEPTH)
   ) else $error("TX FIFO fill count above depth");

endmodule

/* tx_frontend/tx_fe_corr.sv */
module tx_fe_corr (
   input  logic              radio_clk,
   input  logic              rst_n_i,
   input  logic              pop_i,
   input  radio_fe_pkg::iq_t pop_iq_i,
   fe_cfg_if.tx              cfg,
   output logic              dac_valid_o,
   output radio_fe_pkg::iq_t dac_iq_o
);
   import radio_fe_pkg::*;

   sample_t in_i;
   sample_t in_q;
   sample_t corr_i;
   sample_t corr_q;
   iq_t     mux_iq;

   assign in_i = sample_t'(pop_iq_i[31:16]);
   assign in_q = sample_t'(pop_iq_i[15:0]);

   ////////////////////////////////////////
   // DC offset and IQ swap
   ////////////////////////////////////////
   always_comb begin
      corr_i = sat_add(in_i, cfg.tx_off_i);
      corr_q = sat_add(in_q, cfg.tx_off_q);
      if (cfg.tx_swap)
         mux_iq = {corr_q, corr_i};
      else
         mux_iq = {corr_i, corr_q};
   end

   // Output stage, data only loads on a pop
   always_ff @(posedge radio_clk) begin
      if (pop_i)
         dac_iq_o <= mux_iq;
   end

   always_ff @(posedge radio_clk) begin
      if (!rst_n_i)
         dac_valid_o <= 1'b0;
      else
         dac_valid_o <= pop_i;
   end

endmodule

/* rx_frontend/rx_fe_corr.sv */
module rx_fe_corr (
   input  logic              radio_clk,
   input  logic              rst_n_i,
   input  radio_fe_pkg::iq_t adc_iq_i,
   fe_cfg_if.rx              cfg,
   output logic              rx_valid_o,
   output radio_fe_pkg::iq_t rx_iq_o
);
   import radio_fe_pkg::*;

   sample_t    s1_i;   // After DC offset
   sample_t    s1_q;
   sample_t    map_i;
   sample_t    map_q;
   logic [1:0] vld_sr;

   ////////////////////////////////////////
   // Stage 1: DC offset removal
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      s1_i <= sat_sub(sample_t'(adc_iq_i[31:16]), cfg.rx_off_i);
      s1_q <= sat_sub(sample_t'(adc_iq_i[15:0]), cfg.rx_off_q);
   end

   ////////////////////////////////////////
   // Stage 2: IQ mapping
   ////////////////////////////////////////
   always_comb begin
      if (cfg.rx_swap) begin
         map_i = s1_q;
         map_q = s1_i;
      end else begin
         map_i = s1_i;
         map_q = s1_q;
      end
      // -32768 clips to 32767
      if (cfg.rx_neg_q)
         map_q = sat_sub('0, map_q);
   end

   always_ff @(posedge radio_clk) begin
      rx_iq_o <= {map_i, map_q};
   end

   // Fill marker, one bit per pipeline stage
   always_ff @(posedge radio_clk) begin
      if (!rst_n_i)
         vld_sr <= 2'b00;
      else
         vld_sr <= {vld_sr[0], 1'b1};
   end

   assign rx_valid_o = vld_sr[1];

   a_rx_out_known : assert property (
      @(posedge radio_clk) disable iff (!rst_n_i)
      rx_valid_o |-> !$isunknown(rx_iq_o)
   ) else $error("RX output unknown while valid");

endmodule

/* rtl/radio_fe_top.sv */
module radio_fe_top #(
   parameter int TX_FIFO_DEPTH = 4
) (
   input  logic                  radio_clk,
   input  logic                  rst_n_i,

   // Settings bus
   input  logic                  set_stb_i,
   input  radio_fe_pkg::set_addr_t set_addr_i,
   input  radio_fe_pkg::set_data_t set_data_i,

   // TX samples in, credit return
   input  logic                  tx_valid_i,
   input  radio_fe_pkg::iq_t     tx_iq_i,
   output logic                  tx_credit_o,

   // DAC side
   output logic                  dac_valid_o,
   output radio_fe_pkg::iq_t     dac_iq_o,

   // ADC side
   input  radio_fe_pkg::iq_t     adc_iq_i,
   output logic                  rx_valid_o,
   output radio_fe_pkg::iq_t     rx_iq_o
);
   import radio_fe_pkg::*;

   logic pop;      // FIFO to correction
   iq_t  pop_iq;

   fe_cfg_if cfg_if ();

   ////////////////////////////////////////
   // Settings registers
   ////////////////////////////////////////
   fe_settings_regs settings_regs_i (
      .radio_clk  (radio_clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .cfg        (cfg_if)
   );

   ////////////////////////////////////////
   // TX path
   ////////////////////////////////////////
   tx_sample_fifo #(
      .TX_FIFO_DEPTH (TX_FIFO_DEPTH)
   ) tx_fifo_i (
      .radio_clk   (radio_clk),
      .rst_n_i     (rst_n_i),
      .tx_valid_i  (tx_valid_i),
      .tx_iq_i     (tx_iq_i),
      .cfg         (cfg_if),
      .pop_o       (pop),
      .pop_iq_o    (pop_iq),
      .tx_credit_o (tx_credit_o)
   );

   tx_fe_corr tx_fe_corr_i (
      .radio_clk   (radio_clk),
      .rst_n_i     (rst_n_i),
      .pop_i       (pop),
      .pop_iq_i    (pop_iq),
      .cfg         (cfg_if),
      .dac_valid_o (dac_valid_o),
      .dac_iq_o    (dac_iq_o)
   );

   ////////////////////////////////////////
   // RX path
   ////////////////////////////////////////
   rx_fe_corr rx_fe_corr_i (
      .radio_clk  (radio_clk),
      .rst_n_i    (rst_n_i),
      .adc_iq_i   (adc_iq_i),   // ADC strobe is always high
      .cfg        (cfg_if),
      .rx_valid_o (rx_valid_o),
      .rx_iq_o    (rx_iq_o)
   );

endmodule

/* verif/radio_fe_tb.sv */
module radio_fe_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import radio_fe_pkg::*;

   localparam int TX_FIFO_DEPTH = 4;
   localparam int TIMEOUT_CYC   = 500;   // Cycles before a wait gives up

   logic      radio_clk;
   logic      rst_n_i;
   logic      set_stb_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   logic      tx_valid_i;
   iq_t       tx_iq_i;
   logic      tx_credit_o;
   logic      dac_valid_o;
   iq_t       dac_iq_o;
   iq_t       adc_iq_i;
   logic      rx_valid_o;
   iq_t       rx_iq_o;

   // Copy of what has been programmed
   sample_t tx_oi;
   sample_t tx_oq;
   sample_t rx_oi;
   sample_t rx_oq;
   logic    tx_sw;
   logic    rx_sw;
   logic    rx_ng;

   int          err_value;
   int          err_other;
   int          tx_credits;    // Producer side credit count
   logic [31:0] lcg_state;
   iq_t         tx_exp_q[$];   // Expected DAC words in order

   radio_fe_top #(
      .TX_FIFO_DEPTH (TX_FIFO_DEPTH)
   ) dut_i (
      .radio_clk   (radio_clk),
      .rst_n_i     (rst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .tx_valid_i  (tx_valid_i),
      .tx_iq_i     (tx_iq_i),
      .tx_credit_o (tx_credit_o),
      .dac_valid_o (dac_valid_o),
      .dac_iq_o    (dac_iq_o),
      .adc_iq_i    (adc_iq_i),
      .rx_valid_o  (rx_valid_o),
      .rx_iq_o     (rx_iq_o)
   );

   initial begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;
   end

   ////////////////////////////////////////
   // Random data and reference model
   ////////////////////////////////////////
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic iq_t rand_iq();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi[31:16], lo[31:16]};   // Upper bits are the better ones
   endfunction

   function automatic sample_t clip(int v);
      if (v > 32767)
         return sample_t'(32767);
      if (v < -32768)
         return sample_t'(-32768);
      return sample_t'(v);
   endfunction

   function automatic iq_t tx_model(iq_t x);
      sample_t xi;
      sample_t xq;
      sample_t yi;
      sample_t yq;
      xi = x[31:16];
      xq = x[15:0];
      yi = clip(int'(xi) + int'(tx_oi));
      yq = clip(int'(xq) + int'(tx_oq));
      return tx_sw ? {yq, yi} : {yi, yq};
   endfunction

   function automatic iq_t rx_model(iq_t x);
      sample_t xi;
      sample_t xq;
      sample_t yi;
      sample_t yq;
      sample_t t;
      xi = x[31:16];
      xq = x[15:0];
      yi = clip(int'(xi) - int'(rx_oi));
      yq = clip(int'(xq) - int'(rx_oq));
      if (rx_sw) begin
         t  = yi;
         yi = yq;
         yq = t;
      end
      if (rx_ng)
         yq = clip(-int'(yq));   // Most negative value clips
      return {yi, yq};
   endfunction

   ////////////////////////////////////////
   // Compare and report
   ////////////////////////////////////////
   task automatic check_iq(input string name, input iq_t exp, input iq_t act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
         err_value++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
         err_value++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("Failure at %0t: %s", $time, msg);
      err_other++;
   endtask

   ////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(negedge radio_clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge radio_clk);
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
   endtask

   // Junk in the upper half must be ignored
   task automatic set_tx_fe(input sample_t oi, input sample_t oq, input logic swap);
      write_setting(set_addr_t'(SET_TX_FE_BASE + 0), {16'ha5a5, oi});
      write_setting(set_addr_t'(SET_TX_FE_BASE + 1), {16'h5a5a, oq});
      write_setting(set_addr_t'(SET_TX_FE_BASE + 4), {31'd0, swap});
      tx_oi = oi;
      tx_oq = oq;
      tx_sw = swap;
   endtask

   task automatic set_rx_fe(input sample_t oi, input sample_t oq, input logic swap,
                            input logic neg);
      write_setting(set_addr_t'(SET_RX_FE_BASE + 2), {16'ha5a5, oi});
      write_setting(set_addr_t'(SET_RX_FE_BASE + 3), {16'h5a5a, oq});
      write_setting(set_addr_t'(SET_RX_FE_BASE + 4), {30'd0, neg, swap});
      rx_oi = oi;
      rx_oq = oq;
      rx_sw = swap;
      rx_ng = neg;
   endtask

   task automatic set_tx_enable(input logic en);
      write_setting(set_addr_t'(SET_CTRL_ADDR), {31'd0, en});
   endtask

   ////////////////////////////////////////
   // Stream drivers
   ////////////////////////////////////////
   // Each output is checked 2 cycles after its input
   task automatic rx_stream(input int n_rand, input bit with_edges);
      iq_t src[$];
      iq_t exp_q[$];
      if (with_edges) begin
         src.push_back(32'h8000_8000);
         src.push_back(32'h7fff_7fff);
         src.push_back(32'h8000_7fff);
         src.push_back(32'h7fff_8000);
         src.push_back(32'h0000_0000);
      end
      for (int k = 0; k < n_rand; k++)
         src.push_back(rand_iq());
      foreach (src[k]) begin
         @(negedge radio_clk);
         if (exp_q.size() == 2) begin
            check_bit("rx_valid_o", 1'b1, rx_valid_o);
            check_iq("rx_iq_o", exp_q.pop_front(), rx_iq_o);
         end
         adc_iq_i = src[k];
         exp_q.push_back(rx_model(src[k]));
      end
      while (exp_q.size() > 0) begin   // Drain the pipeline
         @(negedge radio_clk);
         check_bit("rx_valid_o", 1'b1, rx_valid_o);
         check_iq("rx_iq_o", exp_q.pop_front(), rx_iq_o);
      end
   endtask

   // Credit return and DAC output, once per cycle
   task automatic collect_tx();
      if (tx_credit_o)
         tx_credits++;
      if (dac_valid_o) begin
         if (tx_exp_q.size() == 0)
            report_failure("dac_valid_o high with no TX sample outstanding");
         else
            check_iq("dac_iq_o", tx_exp_q.pop_front(), dac_iq_o);
      end
   endtask

   task automatic tx_run(input int n_rand, input bit with_edges);
      iq_t         src[$];
      logic [31:0] r;
      int          idx;
      int          cycles;
      idx    = 0;
      cycles = 0;
      if (with_edges) begin
         src.push_back(32'h7fff_8000);
         src.push_back(32'h8000_7fff);
         src.push_back(32'h0000_0000);
         src.push_back(32'hffff_0001);
      end
      for (int k = 0; k < n_rand; k++)
         src.push_back(rand_iq());
      while ((idx < src.size() || tx_exp_q.size() > 0) && cycles < TIMEOUT_CYC) begin
         @(negedge radio_clk);
         cycles++;
         collect_tx();
         r = lcg_next();
         // Gaps now and then, never beyond the credits held
         if (idx < src.size() && tx_credits > 0 && r[29:28] != 2'b00) begin
            tx_valid_i = 1'b1;
            tx_iq_i    = src[idx];
            tx_exp_q.push_back(tx_model(src[idx]));
            tx_credits--;
            idx++;
         end else begin
            tx_valid_i = 1'b0;
         end
      end
      tx_valid_i = 1'b0;
      if (idx < src.size() || tx_exp_q.size() > 0)
         report_failure("timeout waiting for TX samples at the DAC");
      if (tx_credits != TX_FIFO_DEPTH)
         report_failure($sformatf("%0d TX credits held after drain, expected %0d",
                                  tx_credits, TX_FIFO_DEPTH));
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////
   task automatic test_reset();
      iq_t x;
      check_bit("tx_credit_o", 1'b0, tx_credit_o);
      check_bit("dac_valid_o", 1'b0, dac_valid_o);
      check_bit("rx_valid_o", 1'b0, rx_valid_o);
      x = rand_iq();
      @(negedge radio_clk);
      check_bit("rx_valid_o", 1'b0, rx_valid_o);   // Only one sample in so far
      adc_iq_i = x;
      @(negedge radio_clk);
      adc_iq_i = ~x;   // Next sample differs
      @(negedge radio_clk);
      check_bit("rx_valid_o", 1'b1, rx_valid_o);
      check_iq("rx_iq_o", x, rx_iq_o);   // Neutral settings pass it through
   endtask

   task automatic test_rx_mapping();
      for (int m = 0; m < 4; m++) begin
         set_rx_fe(16'sd0, 16'sd0, m[0], m[1]);
         rx_stream(12, 1'b1);
         set_rx_fe(16'sd28672, -16'sd28672, m[0], m[1]);
         rx_stream(12, 1'b1);
         set_rx_fe(-16'sd1234, 16'sd517, m[0], m[1]);
         rx_stream(12, 1'b1);
      end
   endtask

   task automatic test_tx_corr();
      set_tx_fe(16'sd12000, -16'sd20000, 1'b1);
      set_tx_enable(1'b1);
      tx_run(40, 1'b1);
      set_tx_fe(-16'sd300, 16'sd32000, 1'b0);
      tx_run(24, 1'b1);
   endtask

   task automatic test_tx_backpressure();
      int cycles;
      set_tx_enable(1'b0);
      for (int k = 0; k < TX_FIFO_DEPTH; k++) begin
         @(negedge radio_clk);
         tx_valid_i = 1'b1;
         tx_iq_i    = rand_iq();
         tx_exp_q.push_back(tx_model(tx_iq_i));
         tx_credits--;
      end
      for (int k = 0; k < 20; k++) begin   // FIFO full and held
         @(negedge radio_clk);
         tx_valid_i = 1'b0;
         check_bit("dac_valid_o", 1'b0, dac_valid_o);
         check_bit("tx_credit_o", 1'b0, tx_credit_o);
      end
      set_tx_enable(1'b1);
      cycles = 0;
      while (tx_exp_q.size() > 0 && cycles < TIMEOUT_CYC) begin
         @(negedge radio_clk);
         cycles++;
         collect_tx();
      end
      if (tx_exp_q.size() > 0)
         report_failure("timeout waiting for held TX samples after enable");
      repeat (4) begin   // No stray credits afterwards
         @(negedge radio_clk);
         collect_tx();
      end
      if (tx_credits != TX_FIFO_DEPTH)
         report_failure($sformatf("%0d TX credits returned after stall, expected %0d",
                                  tx_credits, TX_FIFO_DEPTH));
   endtask

   task automatic test_ignored_write();
      write_setting(set_addr_t'(230), 32'hffff_ffff);
      write_setting(set_addr_t'(SET_RX_FE_BASE + 1), 32'hffff_ffff);
      rx_stream(8, 1'b1);
      tx_run(8, 1'b1);
   endtask

   initial begin
      rst_n_i    = 1'b0;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      tx_valid_i = 1'b0;
      tx_iq_i    = '0;
      adc_iq_i   = '0;
      tx_oi      = '0;
      tx_oq      = '0;
      rx_oi      = '0;
      rx_oq      = '0;
      tx_sw      = 1'b0;
      rx_sw      = 1'b0;
      rx_ng      = 1'b0;
      err_value  = 0;
      err_other  = 0;
      tx_credits = TX_FIFO_DEPTH;
      lcg_state  = 32'd50217;
      repeat (2) @(posedge radio_clk);
      @(negedge radio_clk);
      rst_n_i = 1'b1;

      test_reset();
      test_rx_mapping();
      test_tx_corr();
      test_tx_backpressure();
      test_ignored_write();

      $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
      if (err_value == 0 && err_other == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* radio_fe.f */
common/radio_fe_pkg.sv
common/fe_cfg_if.sv
rtl/fe_settings_regs.sv
tx_frontend/tx_sample_fifo.sv
tx_frontend/tx_fe_corr.sv
rx_frontend/rx_fe_corr.sv
rtl/radio_fe_top.sv
verif/radio_fe_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= radio_fe_tb
FILELIST  ?= radio_fe.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
